// ==== src.f ====
+incdir+logic
logic/hdmi_cfg_pkg.sv
logic/i2c_byte_engine.sv
logic/reg_write_sequencer.sv
logic/hdmi_tx_init.sv
logic/hdmi_cfg_top.sv
verification/i2c_target_model.sv
verification/hdmi_cfg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the hdmi configuration testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module hdmi_cfg_tb -o hdmi_cfg_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/hdmi_cfg_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the run only counts as good when the testbench printed its pass line
if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
echo "pass line not found in the simulation output"
exit 1

// ==== verification/hdmi_cfg_tb.sv ====
`timescale 1ns/1ps
`include "hdmi_cfg_config.svh"

module hdmi_cfg_tb
    import hdmi_cfg_pkg::*;
();

    localparam int LEN  = `HDMI_INIT_LEN;
    localparam int ROWS = 4;
    // start, three nine-bit bytes and stop, four quarters each, plus issue slack
    localparam int XFER_CYCLES = 4 * (1 + 3 * 9 + 1) * `I2C_QUARTER_DIV + 16;
    localparam int LIMIT       = ROWS * (LEN + 2) * XFER_CYCLES * 2;

    // where the interrupt pulse goes
    localparam int INT_NONE  = 0;
    localparam int INT_READY = 1;
    localparam int INT_RUN   = 2;

    // scenario table, one array per column
    localparam bit ROW_NACK   [ROWS] = '{1'b0, 1'b1, 1'b0, 1'b0};
    localparam int ROW_INT    [ROWS] = '{INT_NONE, INT_NONE, INT_READY, INT_RUN};
    // cycles before the pulse, from ready or from reset release
    localparam int ROW_DELAY  [ROWS] = '{0, 0, 20, 3000};
    // acknowledged writes expected in the target log
    localparam int ROW_WRITES [ROWS] = '{24, 24, 48, 24};

    // register in the high byte, value in the low byte
    localparam logic [15:0] EXP_PAIRS [LEN] = '{
        16'h4110, 16'h9803, 16'h9AE0, 16'h9C30, 16'h9D01, 16'hA2A4,
        16'hA3A4, 16'hE0D0, 16'hF900, 16'h1500, 16'h1630,
        {8'h17, 6'd0, `HDMI_ASPECT_WIDE, 1'b0},
        16'h1846, 16'hAF06, 16'hBA00, 16'h0A00, 16'h0100, 16'h0218,
        16'h0380, 16'h0B0E, 16'h0C05, 16'h0D10, 16'h94C0, 16'h96C0
    };

    logic        clk = 1'b0;
    logic        reset;
    logic        hdmi_int;
    logic        ready;
    logic        scl_low;
    logic        sda_low;
    logic        tgt_sda_low;
    logic        scl;
    logic        sda;
    logic        clear;
    int          refuse_at;
    int          protocol_errors;
    logic [31:0] rng_state;
    int          cycles = 0;
    int          errors;
    int          passes;
    int          fails;

    // open drain lines, any low driver wins
    assign scl = ~scl_low;
    assign sda = ~(sda_low | tgt_sda_low);

    always #10 clk = ~clk;

    hdmi_cfg_top UUT (
        .clk      (clk),
        .reset    (reset),
        .hdmi_int (hdmi_int),
        .ready    (ready),
        .scl_low  (scl_low),
        .sda_low  (sda_low),
        .sda_in   (sda)
    );

    i2c_target_model target (
        .clk         (clk),
        .clear       (clear),
        .refuse_at   (refuse_at),
        .scl         (scl),
        .sda         (sda),
        .sda_low     (tgt_sda_low),
        .error_count (protocol_errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic check_byte(input string name, input i2c_byte_t got, input i2c_byte_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is 0x%02h, expected 0x%02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // one logged transfer against table entry idx
    task automatic compare_logged_write(input int pos, input int idx, input logic ok);
        if (pos < target.log_count) begin
            check_byte($sformatf("address byte of transfer %0d", pos),
                       target.log_chip[pos], {`HDMI_CHIP_ADDR, 1'b0});
            check_byte($sformatf("register of transfer %0d", pos),
                       target.log_reg[pos], EXP_PAIRS[idx][15:8]);
            check_byte($sformatf("value of transfer %0d", pos),
                       target.log_val[pos], EXP_PAIRS[idx][7:0]);
            check_flag($sformatf("acknowledge of transfer %0d", pos), target.log_ok[pos], ok);
        end
    endtask

    task automatic wait_ready(input logic level);
        while (ready !== level) begin
            @(negedge clk);
        end
    endtask

    task automatic run_scenario(input int r);
        int errs_before;
        int refuse;
        int k;
        int pos;
        errs_before = errors;
        refuse = -1;
        if (ROW_NACK[r]) begin
            rng_state = xorshift32(rng_state);
            refuse = int'(rng_state % 32'(LEN));
        end
        // hold the DUT in reset and empty the target log
        @(posedge clk);
        reset     <= 1'b0;
        clear     <= 1'b1;
        hdmi_int  <= 1'b1;
        refuse_at <= refuse;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        clear <= 1'b0;
        @(negedge clk);
        check_flag("ready", ready, 1'b0);
        if (ROW_INT[r] == INT_RUN) begin
            repeat (ROW_DELAY[r]) @(posedge clk);
            hdmi_int <= 1'b0;
            repeat (4) @(posedge clk);
            hdmi_int <= 1'b1;
            // table still running, the pulse is ignored
            @(negedge clk);
            check_flag("ready", ready, 1'b0);
        end
        wait_ready(1'b1);
        if (ROW_INT[r] == INT_READY) begin
            repeat (ROW_DELAY[r]) @(posedge clk);
            hdmi_int <= 1'b0;
            // low level sampled on this edge, ready drops with it
            @(posedge clk);
            @(negedge clk);
            check_flag("ready", ready, 1'b0);
            @(posedge clk);
            hdmi_int <= 1'b1;
            wait_ready(1'b1);
        end
        // room for a stray extra write to reach the log
        repeat (2 * XFER_CYCLES) @(posedge clk);
        @(negedge clk);
        check_flag("ready", ready, 1'b1);
        pos = 0;
        for (k = 0; k < ROW_WRITES[r]; k++) begin
            if (k == refuse) begin
                // refused copy first, then the retry
                compare_logged_write(pos, k % LEN, 1'b0);
                pos++;
            end
            compare_logged_write(pos, k % LEN, 1'b1);
            pos++;
        end
        if (target.log_count != pos) begin
            note_failure($sformatf("target logged %0d transfers where %0d were expected",
                                   target.log_count, pos));
        end
        if (protocol_errors != 0) begin
            note_failure($sformatf("target saw %0d bus protocol errors", protocol_errors));
        end
        if (errors == errs_before) begin
            passes++;
        end else begin
            fails++;
        end
        $display("scenario %0d: nack entry %0d, interrupt mode %0d, %0d transfers: %s",
                 r, refuse, ROW_INT[r], target.log_count,
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    // watchdog sized from the scenario table
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles with the scenarios unfinished", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int r;
        reset     = 1'b0;
        hdmi_int  = 1'b1;
        clear     = 1'b1;
        refuse_at = -1;
        rng_state = 32'd51307;
        errors    = 0;
        passes    = 0;
        fails     = 0;
        for (r = 0; r < ROWS; r++) begin
            run_scenario(r);
        end
        $display("scenarios passed %0d, failed %0d, failed checks %0d", passes, fails, errors);
        if ((fails == 0) && (errors == 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verification/i2c_target_model.sv ====
`timescale 1ns/1ps

module i2c_target_model (
    input  logic clk,
    input  logic clear,
    input  int   refuse_at,
    input  logic scl,
    input  logic sda,
    output logic sda_low,
    output int   error_count
);

    localparam int DEPTH = 64;

    // one record per transfer closed by a stop
    logic [7:0]  log_chip [DEPTH];
    logic [7:0]  log_reg  [DEPTH];
    logic [7:0]  log_val  [DEPTH];
    logic        log_ok   [DEPTH];
    int          log_count;
    // acknowledged writes so far, picks the write to refuse
    int          ok_count;

    logic        scl_q;
    logic        sda_q;
    logic        active;
    logic        nacked;
    // only one refusal per run
    logic        refused;
    int          bit_cnt;
    int          byte_cnt;
    logic [7:0]  shift;
    // address, register and value bytes in arrival order
    logic [23:0] xfer;

    task automatic protocol_error(input string what);
        $display("protocol error at %0t ns: %s", $time, what);
        error_count <= error_count + 1;
    endtask

    // bus oversampled on the system clock, every level lasts a quarter bit
    always @(posedge clk) begin
        if (clear) begin
            sda_low     <= 1'b0;
            error_count <= 0;
            log_count   <= 0;
            ok_count    <= 0;
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;
            active      <= 1'b0;
            nacked      <= 1'b0;
            refused     <= 1'b0;
            bit_cnt     <= 0;
            byte_cnt    <= 0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && (sda != sda_q)) begin
                // sda moved under a high scl, must be a start or a stop
                if (!sda) begin
                    if (active) begin
                        protocol_error("start inside an open transfer");
                    end
                    active   <= 1'b1;
                    nacked   <= 1'b0;
                    bit_cnt  <= 0;
                    byte_cnt <= 0;
                end else if (!active) begin
                    protocol_error("stop without a start");
                end else begin
                    active <= 1'b0;
                    // the stop's own scl rise was counted as one bit
                    if ((bit_cnt != 1) || (byte_cnt != 3)) begin
                        protocol_error($sformatf("stop after %0d bytes and %0d bits",
                                                 byte_cnt, bit_cnt));
                    end else if (log_count < DEPTH) begin
                        log_chip[log_count] <= xfer[23:16];
                        log_reg[log_count]  <= xfer[15:8];
                        log_val[log_count]  <= xfer[7:0];
                        log_ok[log_count]   <= !nacked;
                        log_count           <= log_count + 1;
                        if (!nacked) begin
                            ok_count <= ok_count + 1;
                        end
                    end
                end
            end else if (scl && !scl_q) begin
                if (!active) begin
                    protocol_error("scl pulse outside a transfer");
                end else if (bit_cnt < 8) begin
                    // msb first
                    shift   <= {shift[6:0], sda};
                    bit_cnt <= bit_cnt + 1;
                end else begin
                    // acknowledge clock
                    bit_cnt  <= 0;
                    byte_cnt <= byte_cnt + 1;
                end
            end else if (!scl && scl_q) begin
                if (sda_low) begin
                    // acknowledge clock over, hand sda back
                    sda_low <= 1'b0;
                end else if (active && (bit_cnt == 8)) begin
                    xfer <= {xfer[15:0], shift};
                    if ((byte_cnt == 2) && !refused && (ok_count == refuse_at)) begin
                        // leave the value byte unacknowledged once
                        nacked  <= 1'b1;
                        refused <= 1'b1;
                    end else begin
                        sda_low <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/hdmi_cfg_top.sv ====
`timescale 1ns/1ps

module hdmi_cfg_top
    import hdmi_cfg_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic hdmi_int,
    output logic ready,
    output logic scl_low,
    output logic sda_low,
    input  logic sda_in
);

    // init table to register write
    logic [6:0] chip_addr;
    i2c_byte_t  reg_addr;
    i2c_byte_t  wr_value;
    logic       wr_start;
    logic       wr_done;
    logic       wr_nack;

    // register write to byte engine
    byte_op_t   op;
    i2c_byte_t  op_data;
    logic       op_valid;
    logic       op_ready;
    logic       op_done;
    logic       op_ack;

    hdmi_tx_init u_init (
        .clk       (clk),
        .reset     (reset),
        .hdmi_int  (hdmi_int),
        .ready     (ready),
        .chip_addr (chip_addr),
        .reg_addr  (reg_addr),
        .wr_value  (wr_value),
        .wr_start  (wr_start),
        .wr_done   (wr_done),
        .wr_nack   (wr_nack)
    );

    reg_write_sequencer u_seq (
        .clk       (clk),
        .reset     (reset),
        .chip_addr (chip_addr),
        .reg_addr  (reg_addr),
        .wr_value  (wr_value),
        .wr_start  (wr_start),
        .wr_done   (wr_done),
        .wr_nack   (wr_nack),
        .op        (op),
        .op_data   (op_data),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .op_done   (op_done),
        .op_ack    (op_ack)
    );

    // pins are drive-low only, the board resolves the open drain
    i2c_byte_engine u_engine (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .op_data  (op_data),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op_done  (op_done),
        .op_ack   (op_ack),
        .scl_low  (scl_low),
        .sda_low  (sda_low),
        .sda_in   (sda_in)
    );

endmodule

// ==== logic/hdmi_tx_init.sv ====
`timescale 1ns/1ps
`include "hdmi_cfg_config.svh"

module hdmi_tx_init
    import hdmi_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       hdmi_int,
    output logic       ready,
    output logic [6:0] chip_addr,
    output i2c_byte_t  reg_addr,
    output i2c_byte_t  wr_value,
    output logic       wr_start,
    input  logic       wr_done,
    input  logic       wr_nack
);

    localparam int LEN = `HDMI_INIT_LEN;
    localparam int EW  = $clog2(LEN);

    init_state_t   state;
    logic [EW-1:0] entry;
    logic          last_entry;
    // register in the high byte, value in the low byte
    logic [15:0]   entry_word;

    assign chip_addr  = `HDMI_CHIP_ADDR;
    assign last_entry = (entry == EW'(LEN - 1));
    assign reg_addr   = entry_word[15:8];
    assign wr_value   = entry_word[7:0];

    // entry only moves on wr_done so the bytes stay put during a transfer
    always_comb begin
        case (entry)
            // all circuits powered up, sync adjust off
            0:  entry_word = 16'h41_10;
            // fixed registers from the chip programming guide
            1:  entry_word = 16'h98_03;
            2:  entry_word = 16'h9A_E0;
            3:  entry_word = 16'h9C_30;
            4:  entry_word = 16'h9D_01;
            5:  entry_word = 16'hA2_A4;
            6:  entry_word = 16'hA3_A4;
            7:  entry_word = 16'hE0_D0;
            8:  entry_word = 16'hF9_00;
            // 44.1 kHz i2s, 24 bit rgb 4:4:4 with separate syncs
            9:  entry_word = 16'h15_00;
            // 4:4:4 out, 8 bit colour depth
            10: entry_word = 16'h16_30;
            // sync polarity passed through, bit 1 picks the aspect ratio
            11: entry_word = 16'h17_00 | {14'd0, `HDMI_ASPECT_WIDE, 1'b0};
            // csc disabled
            12: entry_word = 16'h18_46;
            // hdmi mode, no hdcp
            13: entry_word = 16'hAF_06;
            // clock delay and hdcp eeprom defaults
            14: entry_word = 16'hBA_00;
            // automatic cts, i2s audio, 128xfs mclk
            15: entry_word = 16'h0A_00;
            // n = 0x1880 for 44.1 kHz, spread over three registers
            16: entry_word = 16'h01_00;
            17: entry_word = 16'h02_18;
            18: entry_word = 16'h03_80;
            // spdif off, mclk internal
            19: entry_word = 16'h0B_0E;
            // i2s0 only, right justified
            20: entry_word = 16'h0C_05;
            // 16 bit i2s samples
            21: entry_word = 16'h0D_10;
            // hpd and monitor sense interrupts enabled
            22: entry_word = 16'h94_C0;
            // clear pending hpd and monitor sense flags
            23: entry_word = 16'h96_C0;
            default: entry_word = 16'h00_00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= INIT_ISSUE;
            entry    <= '0;
            wr_start <= 1'b0;
            ready    <= 1'b0;
        end else begin
            wr_start <= 1'b0;
            case (state)
                INIT_ISSUE: begin
                    wr_start <= 1'b1;
                    state    <= INIT_WAIT;
                end
                INIT_WAIT: begin
                    if (wr_done) begin
                        if (wr_nack) begin
                            // a refused entry goes out again
                            state <= INIT_ISSUE;
                        end else if (last_entry) begin
                            // pll lock is not checked before ready
                            entry <= '0;
                            ready <= 1'b1;
                            state <= INIT_IDLE;
                        end else begin
                            entry <= entry + 1'b1;
                            state <= INIT_ISSUE;
                        end
                    end
                end
                INIT_IDLE: begin
                    // interrupt means hotplug, so rewrite the whole table
                    if (!hdmi_int) begin
                        ready <= 1'b0;
                        state <= INIT_ISSUE;
                    end
                end
                default: state <= INIT_ISSUE;
            endcase
        end
    end

    // no transfer may complete once the table is reported done
    assert property (@(posedge clk) disable iff (!reset)
        wr_done |-> !ready);

endmodule

// ==== logic/reg_write_sequencer.sv ====
`timescale 1ns/1ps

module reg_write_sequencer
    import hdmi_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] chip_addr,
    input  i2c_byte_t  reg_addr,
    input  i2c_byte_t  wr_value,
    input  logic       wr_start,
    output logic       wr_done,
    output logic       wr_nack,
    output byte_op_t   op,
    output i2c_byte_t  op_data,
    output logic       op_valid,
    input  logic       op_ready,
    input  logic       op_done,
    input  logic       op_ack
);

    seq_state_t state;
    // current state's command already taken by the engine
    logic       issued;

    // one command per state, offered until accepted
    assign op_valid = (state != SEQ_IDLE) && !issued;

    always_comb begin
        op      = OP_WRITE;
        op_data = '0;
        case (state)
            SEQ_START: op = OP_START;
            // r/w bit clear for a write
            SEQ_ADDR:  op_data = {chip_addr, 1'b0};
            SEQ_REG:   op_data = reg_addr;
            SEQ_VALUE: op_data = wr_value;
            SEQ_STOP:  op = OP_STOP;
            default:   op = OP_START;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state   <= SEQ_IDLE;
            issued  <= 1'b0;
            wr_done <= 1'b0;
            wr_nack <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (op_valid && op_ready) begin
                issued <= 1'b1;
            end
            case (state)
                SEQ_IDLE: begin
                    if (wr_start) begin
                        state   <= SEQ_START;
                        issued  <= 1'b0;
                        wr_nack <= 1'b0;
                    end
                end
                SEQ_START: begin
                    if (op_done) begin
                        state  <= SEQ_ADDR;
                        issued <= 1'b0;
                    end
                end
                SEQ_ADDR, SEQ_REG, SEQ_VALUE: begin
                    if (op_done) begin
                        issued <= 1'b0;
                        if (!op_ack) begin
                            // first refused byte ends the transfer early
                            wr_nack <= 1'b1;
                            state   <= SEQ_STOP;
                        end else if (state == SEQ_ADDR) begin
                            state <= SEQ_REG;
                        end else if (state == SEQ_REG) begin
                            state <= SEQ_VALUE;
                        end else begin
                            state <= SEQ_STOP;
                        end
                    end
                end
                SEQ_STOP: begin
                    if (op_done) begin
                        state   <= SEQ_IDLE;
                        issued  <= 1'b0;
                        wr_done <= 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // init block keeps a single write outstanding
    assert property (@(posedge clk) disable iff (!reset)
        wr_start |-> (state == SEQ_IDLE));

endmodule

// ==== logic/i2c_byte_engine.sv ====
`timescale 1ns/1ps
`include "hdmi_cfg_config.svh"

module i2c_byte_engine
    import hdmi_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  byte_op_t  op,
    input  i2c_byte_t op_data,
    input  logic      op_valid,
    output logic      op_ready,
    output logic      op_done,
    output logic      op_ack,
    output logic      scl_low,
    output logic      sda_low,
    input  logic      sda_in
);

    localparam int QDIV = `I2C_QUARTER_DIV;
    localparam int QW   = (QDIV > 1) ? $clog2(QDIV) : 1;

    logic          busy;
    byte_op_t      cur_op;
    i2c_byte_t     data_q;
    logic [QW-1:0] q_cnt;
    logic [1:0]    q_idx;
    logic [3:0]    bit_cnt;
    logic          q_end;
    logic          last_q;
    logic [1:0]    next_q;
    logic [3:0]    next_bit;
    logic [1:0]    lines_next;

    // pin drive for one quarter, packed as {scl_low, sda_low}
    function automatic logic [1:0] quarter_lines(
        input byte_op_t   f_op,
        input logic [1:0] f_q,
        input logic [3:0] f_bit,
        input i2c_byte_t  f_data
    );
        logic scl_l;
        logic sda_l;
        scl_l = 1'b0;
        sda_l = 1'b0;
        case (f_op)
            OP_START: begin
                // both high, sda falls, then scl is pulled low
                scl_l = (f_q == 2'd3);
                sda_l = (f_q != 2'd0);
            end
            OP_STOP: begin
                // scl rises over a low sda, then sda is let go
                scl_l = (f_q == 2'd0);
                sda_l = (f_q < 2'd2);
            end
            default: begin
                // scl high in the two middle quarters of each bit
                scl_l = (f_q == 2'd0) || (f_q == 2'd3);
                // msb first, ninth bit left to the target
                if (f_bit == 4'd8) begin
                    sda_l = 1'b0;
                end else begin
                    sda_l = ~f_data[3'd7 - f_bit[2:0]];
                end
            end
        endcase
        return {scl_l, sda_l};
    endfunction

    assign op_ready = ~busy;

    // quarter boundary and the very last quarter of the command
    assign q_end    = (q_cnt == QW'(QDIV - 1));
    assign last_q   = (q_idx == 2'd3) && ((cur_op != OP_WRITE) || (bit_cnt == 4'd8));
    assign next_q   = q_idx + 2'd1;
    assign next_bit = (q_idx == 2'd3) ? bit_cnt + 4'd1 : bit_cnt;

    // levels for the quarter that follows the current one
    assign lines_next = quarter_lines(cur_op, next_q, next_bit, data_q);

    always_ff @(posedge clk) begin
        if (!reset) begin
            busy    <= 1'b0;
            cur_op  <= OP_START;
            q_cnt   <= '0;
            q_idx   <= 2'd0;
            bit_cnt <= 4'd0;
            op_done <= 1'b0;
            op_ack  <= 1'b0;
            scl_low <= 1'b0;
            sda_low <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (!busy) begin
                // lines hold their last quarter while idle
                if (op_valid) begin
                    busy    <= 1'b1;
                    cur_op  <= op;
                    q_cnt   <= '0;
                    q_idx   <= 2'd0;
                    bit_cnt <= 4'd0;
                    op_ack  <= 1'b0;
                    {scl_low, sda_low} <= quarter_lines(op, 2'd0, 4'd0, op_data);
                end
            end else begin
                q_cnt <= q_cnt + 1'b1;
                // ack taken at the start of the third quarter, mid-high on scl
                if ((cur_op == OP_WRITE) && (bit_cnt == 4'd8) && (q_idx == 2'd2)
                        && (q_cnt == '0)) begin
                    op_ack <= ~sda_in;
                end
                if (q_end) begin
                    q_cnt <= '0;
                    if (last_q) begin
                        busy    <= 1'b0;
                        op_done <= 1'b1;
                    end else begin
                        q_idx   <= next_q;
                        bit_cnt <= next_bit;
                        {scl_low, sda_low} <= lines_next;
                    end
                end
            end
        end
    end

    // byte to shift out
    always_ff @(posedge clk) begin
        if (!busy && op_valid) begin
            data_q <= op_data;
        end
    end

    // sequencer only offers a command once the previous one has finished
    assert property (@(posedge clk) disable iff (!reset)
        busy |-> !op_valid);

    // data moves only under a low scl, start and stop excepted
    assert property (@(posedge clk) disable iff (!reset)
        (!scl_low && !$past(scl_low) && !(busy && (cur_op != OP_WRITE)))
            |-> $stable(sda_low));

endmodule

// ==== logic/hdmi_cfg_pkg.sv ====
package hdmi_cfg_pkg;

    // one byte on the bus
    // carries the address, register or value of a write
    typedef logic [7:0] i2c_byte_t;

    // commands understood by the byte engine
    typedef enum logic [1:0] {
        // start condition with sda falling while scl is high
        OP_START,
        // eight data bits and then the acknowledge slot
        OP_WRITE,
        // stop condition with sda rising while scl is high
        OP_STOP
    } byte_op_t;

    // init table walker
    typedef enum logic [1:0] {
        // request the current table entry
        INIT_ISSUE,
        // transfer in flight on the bus
        INIT_WAIT,
        // table written, watching the interrupt line
        INIT_IDLE
    } init_state_t;

    // one register write on the bus
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_START,
        // chip address with the write bit
        SEQ_ADDR,
        SEQ_REG,
        SEQ_VALUE,
        SEQ_STOP
    } seq_state_t;

endpackage

// ==== logic/hdmi_cfg_config.svh ====
`ifndef HDMI_CFG_CONFIG_SVH
`define HDMI_CFG_CONFIG_SVH

// 7-bit i2c address of the hdmi transmitter
// the write address byte on the bus is 0x72
`define HDMI_CHIP_ADDR 7'h39

// system clocks per quarter of an scl period
// kept tiny so a full table run stays short in simulation
// a real board would use clk / (4 * scl rate)
`define I2C_QUARTER_DIV 4

// input aspect ratio in register 0x17 bit 1
// 1'b1 selects 16:9 and 1'b0 keeps 4:3
`define HDMI_ASPECT_WIDE 1'b0

// number of register writes in the init table
`define HDMI_INIT_LEN 24

`endif
